// File: hdl/copper_pkg.sv
//**************************************************
// shared definitions for the copper coprocessor
// sizes, raster constants, opcodes, apb register map
// instruction union, beam, register and memory write structs
//**************************************************
package copper_pkg;

    // program memory is 1024 words of 16 bits
    localparam int MEM_ADDR_W = 10;

    // small raster so a frame fits in a short simulation
    localparam int H_TOTAL = 32;
    localparam int V_TOTAL = 24;
    localparam int POS_W   = 12;

    // video register file seen by MOVE
    localparam int REG_ADDR_W = 6;
    localparam int REG_DATA_W = 8;

    // apb bus widths
    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 16;

    // top nibble 0010 waits for a line, top bits 11 move a register
    // anything else decodes as nop
    localparam logic [3:0] OP_WAIT_V = 4'h2;
    localparam logic [1:0] OP_MOVE   = 2'b11;

    // wait for line 4095, which the beam never reaches
    localparam logic [15:0] INSN_WAIT_FOREVER = {OP_WAIT_V, 12'hFFF};

    // apb register map, memory window is write only
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR   = 12'h000;
    localparam logic [APB_ADDR_W-1:0] STATUS_ADDR = 12'h004;
    localparam logic [APB_ADDR_W-1:0] MEM_BASE    = 12'h800;

    // one instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [3:0]            op;
            logic [POS_W-1:0]      line;
        } wait_v;
        struct packed {
            logic [1:0]            op;
            logic [REG_ADDR_W-1:0] addr;
            logic [REG_DATA_W-1:0] data;
        } move;
    } copper_insn_u;

    // beam position, frame_start flags hpos == vpos == 0
    typedef struct packed {
        logic [POS_W-1:0] hpos;
        logic [POS_W-1:0] vpos;
        logic             frame_start;
    } beam_t;

    // register write issued by a MOVE
    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
    } reg_wr_t;

    // host write into copper program memory
    typedef struct packed {
        logic                  en;
        logic [MEM_ADDR_W-1:0] addr;
        copper_insn_u          data;
    } mem_wr_t;

endpackage

// File: hdl/copper_mem.sv
//**************************************************
// copper program memory
// one write port from the host, one registered read
// port for the executor, filled with wait-forever
//**************************************************
`timescale 1ns/10ps

module copper_mem (
    input  logic                              clk,
    input  logic                              reset_i,
    input  copper_pkg::mem_wr_t               mem_wr_i,
    input  logic [copper_pkg::MEM_ADDR_W-1:0] rd_addr_i,
    output copper_pkg::copper_insn_u          rd_data_o
);
    import copper_pkg::*;

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    // block ram array
    copper_insn_u mem [0:DEPTH-1];

    // same-address read and write in one cycle
    logic collide;

    // power-up contents
    // every word waits forever so an unloaded copper issues nothing
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = INSN_WAIT_FOREVER;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (mem_wr_i.en) begin
            mem[mem_wr_i.addr] <= mem_wr_i.data;
        end
    end

    assign collide = mem_wr_i.en && (mem_wr_i.addr == rd_addr_i);

    // registered read, one cycle of latency
    // the bram returns the new word on a same-address write,
    // so the model forwards write data to match the silicon
    always_ff @(posedge clk) begin
        if (collide) begin
            rd_data_o <= mem_wr_i.data;
        end else begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

    // a write with an unknown address would corrupt an unknown word
    a_wr_addr_known: assert property (
        @(posedge clk) disable iff (reset_i)
        mem_wr_i.en |-> !$isunknown(mem_wr_i.addr)
    ) else $error("copper_mem: write enabled with unknown address");

endmodule

// File: hdl/beam_timer.sv
//**************************************************
// beam timer
// horizontal and vertical scan counters
// and the frame start pulse
//**************************************************
`timescale 1ns/10ps

module beam_timer (
    input  logic              clk,
    input  logic              reset_i,
    output copper_pkg::beam_t beam_o
);
    import copper_pkg::*;

    // current scan position
    logic [POS_W-1:0] hpos_q;
    logic [POS_W-1:0] vpos_q;

    // last clock of a line, last line of a frame
    logic h_wrap;
    logic v_wrap;

    assign h_wrap = (hpos_q == POS_W'(H_TOTAL - 1));
    assign v_wrap = (vpos_q == POS_W'(V_TOTAL - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hpos_q <= '0;
            vpos_q <= '0;
        end else if (h_wrap) begin
            // end of line, step to the next line
            hpos_q <= '0;
            if (v_wrap) begin
                vpos_q <= '0;
            end else begin
                vpos_q <= vpos_q + 1'b1;
            end
        end else begin
            hpos_q <= hpos_q + 1'b1;
        end
    end

    // frame start is the single cycle at the top left corner
    always_comb begin
        beam_o.hpos        = hpos_q;
        beam_o.vpos        = vpos_q;
        beam_o.frame_start = (hpos_q == '0) && (vpos_q == '0);
    end

    // counters stay inside the raster
    a_hpos_range: assert property (
        @(posedge clk) disable iff (reset_i)
        hpos_q < POS_W'(H_TOTAL)
    ) else $error("beam_timer: hpos %0d out of range", hpos_q);

    a_vpos_range: assert property (
        @(posedge clk) disable iff (reset_i)
        vpos_q < POS_W'(V_TOTAL)
    ) else $error("beam_timer: vpos %0d out of range", vpos_q);

endmodule

// File: hdl/copper_exec.sv
//**************************************************
// copper executor
// fetch/decode FSM with a program counter
// issues MOVE register writes, stalls on WAIT_V,
// restarts at address 0 on every frame start
//**************************************************
`timescale 1ns/10ps

module copper_exec (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              enable_i,
    input  copper_pkg::beam_t                 beam_i,
    output logic [copper_pkg::MEM_ADDR_W-1:0] rd_addr_o,
    input  copper_pkg::copper_insn_u          rd_data_i,
    output copper_pkg::reg_wr_t               reg_wr_o
);
    import copper_pkg::*;

    // program counter, also the memory read address
    logic [MEM_ADDR_W-1:0] pc_q;

    // fsm state
    // 0 = fetch, address is presented to the memory
    // 1 = decode, instruction word is on rd_data_i
    logic decode_q;

    // decoded instruction
    logic is_move;
    logic is_wait;
    logic wait_done;

    // back to address 0 and no execution
    logic restart;

    // a MOVE leaves decode this cycle
    logic issue_move;

    // registered write toward the video registers
    logic                  wr_valid_q;
    logic [REG_ADDR_W-1:0] wr_addr_q;
    logic [REG_DATA_W-1:0] wr_data_q;

    // both views of the same word, only one opcode can match
    assign is_move   = (rd_data_i.move.op == OP_MOVE);
    assign is_wait   = (rd_data_i.wait_v.op == OP_WAIT_V);
    assign wait_done = (beam_i.vpos >= rd_data_i.wait_v.line);

    // frame start overrides a pending wait
    // a disabled copper sits at address 0
    assign restart    = !enable_i || beam_i.frame_start;
    assign issue_move = decode_q && is_move && !restart;

    assign rd_addr_o = pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q     <= '0;
            decode_q <= 1'b0;
        end else if (restart) begin
            pc_q     <= '0;
            decode_q <= 1'b0;
        end else if (!decode_q) begin
            // memory answers next cycle
            decode_q <= 1'b1;
        end else if (!is_wait || wait_done) begin
            // move, nop, or a wait whose line has come
            pc_q     <= pc_q + 1'b1;
            decode_q <= 1'b0;
        end
        // otherwise hold in decode, re-reading the same word
    end

    // write strobe, one cycle per MOVE
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_valid_q <= 1'b0;
        end else begin
            wr_valid_q <= issue_move;
        end
    end

    // register index and data, only meaningful with the strobe
    always_ff @(posedge clk) begin
        if (issue_move) begin
            wr_addr_q <= rd_data_i.move.addr;
            wr_data_q <= rd_data_i.move.data;
        end
    end

    always_comb begin
        reg_wr_o.valid = wr_valid_q;
        reg_wr_o.addr  = wr_addr_q;
        reg_wr_o.data  = wr_data_q;
    end

    // a write only follows a decode cycle that ran with enable set
    a_no_wr_disabled: assert property (
        @(posedge clk) disable iff (reset_i)
        reg_wr_o.valid |-> $past(enable_i)
    ) else $error("copper_exec: register write while disabled");

    // every MOVE passes through fetch, so strobes never touch
    a_wr_single: assert property (
        @(posedge clk) disable iff (reset_i)
        reg_wr_o.valid |=> !reg_wr_o.valid
    ) else $error("copper_exec: write valid held two cycles");

endmodule

// File: hdl/copper_apb.sv
//**************************************************
// apb slave for the copper
// control register, vpos status readback
// and the program memory write window
//**************************************************
`timescale 1ns/10ps

module copper_apb (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [copper_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [copper_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [copper_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    input  copper_pkg::beam_t                 beam_i,
    output logic                              enable_o,
    output copper_pkg::mem_wr_t               mem_wr_o
);
    import copper_pkg::*;

    // access phase of a transfer
    logic access;
    logic wr_access;

    // address decode
    logic sel_ctrl;
    logic sel_status;
    logic sel_mem;

    // byte offset into the memory window
    logic [APB_ADDR_W-1:0] mem_off;

    // copper enable, ctrl bit 0
    logic enable_q;

    assign access    = psel_i && penable_i;
    assign wr_access = access && pwrite_i;

    assign sel_ctrl   = (paddr_i == CTRL_ADDR);
    assign sel_status = (paddr_i == STATUS_ADDR);
    assign mem_off    = paddr_i - MEM_BASE;

    // window is word aligned, 4 bytes per instruction
    // 12 address bits reach the lower 512 words only
    assign sel_mem = (paddr_i >= MEM_BASE) && (mem_off[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q <= 1'b0;
        end else if (wr_access && sel_ctrl) begin
            enable_q <= pwdata_i[0];
        end
    end

    assign enable_o = enable_q;

    // memory write goes out in the access cycle itself
    always_comb begin
        mem_wr_o.en   = wr_access && sel_mem;
        mem_wr_o.addr = mem_off[MEM_ADDR_W+1:2];
        mem_wr_o.data = pwdata_i;
    end

    // zero wait states
    assign pready_o = 1'b1;

    // status is read only, unmapped writes are errors too
    assign pslverr_o = wr_access && !(sel_ctrl || sel_mem);

    // read mux, memory window and holes read as zero
    always_comb begin
        prdata_o = '0;
        if (sel_ctrl) begin
            prdata_o[0] = enable_q;
        end else if (sel_status) begin
            prdata_o = APB_DATA_W'(beam_i.vpos);
        end
    end

    // access phase never comes without select
    a_penable_psel: assert property (
        @(posedge clk) disable iff (reset_i)
        penable_i |-> psel_i
    ) else $error("copper_apb: penable without psel");

endmodule

// File: hdl/copper_top.sv
//**************************************************
// copper coprocessor top level
// apb slave, program memory, beam timer, executor
//**************************************************
`timescale 1ns/10ps

module copper_top (
    input  logic                              clk,
    input  logic                              reset_i,
    input  logic                              psel_i,
    input  logic                              penable_i,
    input  logic                              pwrite_i,
    input  logic [copper_pkg::APB_ADDR_W-1:0] paddr_i,
    input  logic [copper_pkg::APB_DATA_W-1:0] pwdata_i,
    output logic [copper_pkg::APB_DATA_W-1:0] prdata_o,
    output logic                              pready_o,
    output logic                              pslverr_o,
    output copper_pkg::beam_t                 beam_o,
    output copper_pkg::reg_wr_t               reg_wr_o
);
    import copper_pkg::*;

    // host side
    logic    enable;
    mem_wr_t mem_wr;

    // executor fetch path
    logic [MEM_ADDR_W-1:0] rd_addr;
    copper_insn_u          rd_data;

    copper_apb u_apb (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .beam_i    (beam_o),
        .enable_o  (enable),
        .mem_wr_o  (mem_wr)
    );

    copper_mem u_mem (
        .clk       (clk),
        .reset_i   (reset_i),
        .mem_wr_i  (mem_wr),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // beam position also feeds status and the executor
    beam_timer u_beam (
        .clk     (clk),
        .reset_i (reset_i),
        .beam_o  (beam_o)
    );

    copper_exec u_exec (
        .clk       (clk),
        .reset_i   (reset_i),
        .enable_i  (enable),
        .beam_i    (beam_o),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .reg_wr_o  (reg_wr_o)
    );

endmodule

// File: tb/copper_tb_tasks.svh
//**************************************************
// testbench tasks and helpers
// apb transfers, program loader, expected writes
// bounded waits on the beam, per-test report
//**************************************************
`ifndef COPPER_TB_TASKS_SVH
`define COPPER_TB_TASKS_SVH

// one apb transfer, inputs change 1 ns after the clock
task automatic apb_xfer(input logic is_wr, input logic [APB_ADDR_W-1:0] addr,
                        input logic [APB_DATA_W-1:0] wdata, output logic xfer_err);
    int   cycles;
    logic done;
    cycles = 0;
    done = 1'b0;
    @(posedge clk);
    #1;
    psel = 1'b1;
    pwrite = is_wr;
    paddr = addr;
    pwdata = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    while (!done) begin
        // slave outputs have settled by mid-cycle
        #1;
        rdata = prdata;
        xfer_err = pslverr;
        done = pready;
        @(posedge clk);
        #1;
        cycles++;
        if (!done && cycles > 16) begin
            abort_run("APB slave never raised pready");
        end
    end
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
endtask

task automatic write_reg(input logic [APB_ADDR_W-1:0] addr,
                         input logic [APB_DATA_W-1:0] data);
    logic xfer_err;
    apb_xfer(1'b1, addr, data, xfer_err);
    assert (!xfer_err) else begin
        check_errs++;
        $display("APB write to %h at %0t was refused with pslverr", addr, $time);
    end
endtask

// result lands in rdata
task automatic read_reg(input logic [APB_ADDR_W-1:0] addr);
    logic xfer_err;
    apb_xfer(1'b0, addr, '0, xfer_err);
endtask

// word n of the window sits at MEM_BASE + 4n
task automatic load_program();
    for (int i = 0; i < program_q.size(); i++) begin
        write_reg(MEM_BASE + APB_ADDR_W'(i * 4), program_q[i]);
    end
endtask

// random register index and data for a MOVE on a given line
function automatic exp_wr_t random_move(input logic [POS_W-1:0] on_line);
    exp_wr_t m;
    m.addr = REG_ADDR_W'($random(seed));
    m.data = REG_DATA_W'($random(seed));
    m.vpos = on_line;
    return m;
endfunction

// MOVE encoding, opcode in the top two bits
function automatic logic [15:0] move_word(input exp_wr_t m);
    return {OP_MOVE, m.addr, m.data};
endfunction

// returns 1 ns into the frame start cycle
task automatic wait_frame_start();
    int cycles;
    cycles = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > H_TOTAL * V_TOTAL + 8) begin
            abort_run("no frame start within one frame");
        end
    end while (!beam.frame_start);
endtask

task automatic wait_hpos(input logic [POS_W-1:0] hpos);
    int cycles;
    cycles = 0;
    do begin
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > H_TOTAL + 8) begin
            abort_run("horizontal position never reached");
        end
    end while (beam.hpos != hpos);
endtask

// load with the copper off, enable, then check two whole frames
// the partial frame right after enable is skipped
task automatic run_program(input int n_moves);
    write_reg(CTRL_ADDR, 16'h0000);
    load_program();
    mode = MODE_IGNORE;
    write_reg(CTRL_ADDR, 16'h0001);
    wait_frame_start();
    // a write from the old frame can still be in flight here
    @(posedge clk);
    #1;
    exp_ptr = seen_ptr;
    for (int f = 0; f < 2; f++) begin
        for (int i = 0; i < n_moves; i++) begin
            exp_list[exp_ptr] = move_list[i];
            exp_ptr = exp_ptr + 6'd1;
        end
    end
    mode = MODE_CHECK;
    repeat (2) wait_frame_start();
    mode = MODE_IGNORE;
    assert (seen_ptr == exp_ptr) else begin
        check_errs++;
        $display("%0d expected register writes never appeared", 6'(exp_ptr - seen_ptr));
    end
endtask

task automatic finish_test(input string name);
    int total;
    total = assert_errs + check_errs;
    if (total == errs_mark) begin
        $display("test %s: ok", name);
    end else begin
        $display("test %s: failed with %0d errors", name, total - errs_mark);
        tests_failed++;
    end
    tests_run++;
    errs_mark = total;
endtask

task automatic abort_run(input string what);
    $display("%s at %0t", what, $time);
    $display("*** TEST FAILED ***");
    $finish;
endtask

`endif

// File: tb/copper_tb.sv
//**************************************************
// copper coprocessor testbench top
// clock, reset, dut, test sequence
// and concurrent checks on register writes
//**************************************************
`timescale 1ns/10ps

module copper_tb;
    import copper_pkg::*;

    // one expected register write and the line it lands on
    typedef struct packed {
        logic [REG_ADDR_W-1:0] addr;
        logic [REG_DATA_W-1:0] data;
        logic [POS_W-1:0]      vpos;
    } exp_wr_t;

    // how register writes are judged
    localparam logic [1:0] MODE_IGNORE = 2'd0;
    localparam logic [1:0] MODE_QUIET  = 2'd1;
    localparam logic [1:0] MODE_CHECK  = 2'd2;

    logic                  clk;
    logic                  reset;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    beam_t                 beam;
    reg_wr_t               reg_wr;

    // reference write queue, a ring of 64 entries
    exp_wr_t     exp_list [0:63];
    exp_wr_t     exp_head;
    logic [5:0]  exp_ptr;
    logic [5:0]  seen_ptr;
    logic [1:0]  mode;

    // program image and the moves it holds
    logic [15:0] program_q [$];
    exp_wr_t     move_list [0:3];

    int                    seed;
    int                    assert_errs;
    int                    check_errs;
    int                    errs_mark;
    int                    tests_run;
    int                    tests_failed;
    logic [APB_DATA_W-1:0] rdata;
    logic                  err;
    logic [POS_W-1:0]      line;

    copper_top u_dut (
        .clk       (clk),
        .reset_i   (reset),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .beam_o    (beam),
        .reg_wr_o  (reg_wr)
    );

    `include "copper_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // queue head moves on every checked write
    assign exp_head = exp_list[seen_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            seen_ptr <= '0;
        end else if (mode == MODE_CHECK && reg_wr.valid) begin
            seen_ptr <= seen_ptr + 6'd1;
        end
    end

    // no write at all while the copper should be silent
    a_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (mode == MODE_QUIET) |-> !reg_wr.valid
    ) else begin
        assert_errs++;
        $display("unexpected register write at %0t while the copper should be idle", $time);
    end

    // more writes than the program holds
    a_extra: assert property (
        @(posedge clk) disable iff (reset)
        (mode == MODE_CHECK && reg_wr.valid) |-> (seen_ptr != exp_ptr)
    ) else begin
        assert_errs++;
        $display("register write at %0t with none left in the queue", $time);
    end

    // value and line of each write against the queue head
    a_value: assert property (
        @(posedge clk) disable iff (reset)
        (mode == MODE_CHECK && reg_wr.valid && seen_ptr != exp_ptr) |->
            (reg_wr.addr == exp_head.addr && reg_wr.data == exp_head.data &&
             beam.vpos == exp_head.vpos)
    ) else begin
        assert_errs++;
        $display("Mismatch at %0t: write %h:%h on line %0d, expected %h:%h on line %0d",
                 $time, reg_wr.addr, reg_wr.data, beam.vpos,
                 exp_head.addr, exp_head.data, exp_head.vpos);
    end

    initial begin
        seed = 32'h41b7d3e9;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        mode = MODE_IGNORE;
        exp_ptr = '0;
        assert_errs = 0;
        check_errs = 0;
        errs_mark = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // reset state, then a full frame with the copper disabled
        assert (!reg_wr.valid) else begin
            check_errs++;
            $display("Mismatch at %0t: write valid high right after reset", $time);
        end
        read_reg(CTRL_ADDR);
        assert (rdata == '0) else begin
            check_errs++;
            $display("Mismatch at %0t: CTRL read %h after reset, expected 0000", $time, rdata);
        end
        mode = MODE_QUIET;
        repeat (2) wait_frame_start();
        finish_test("reset and disabled");

        // default memory only waits forever
        write_reg(CTRL_ADDR, 16'h0001);
        repeat (3) wait_frame_start();
        finish_test("unloaded memory");

        // three random moves in line 0
        program_q.delete();
        for (int i = 0; i < 3; i++) begin
            move_list[i] = random_move(POS_W'(0));
            program_q.push_back(move_word(move_list[i]));
        end
        program_q.push_back(INSN_WAIT_FOREVER);
        run_program(3);
        finish_test("three moves");

        // move, wait for line 5, move
        move_list[0] = random_move(POS_W'(0));
        move_list[1] = random_move(POS_W'(5));
        program_q.delete();
        program_q.push_back(move_word(move_list[0]));
        program_q.push_back({OP_WAIT_V, 12'd5});
        program_q.push_back(move_word(move_list[1]));
        program_q.push_back(INSN_WAIT_FOREVER);
        run_program(2);
        finish_test("wait for line");

        // status readback on a few lines
        for (int i = 0; i < 3; i++) begin
            repeat (H_TOTAL * 3) @(posedge clk);
            wait_hpos(POS_W'(4));
            line = beam.vpos;
            read_reg(STATUS_ADDR);
            assert (rdata == APB_DATA_W'(line)) else begin
                check_errs++;
                $display("Mismatch at %0t: STATUS read %h, expected line %0d",
                         $time, rdata, line);
            end
        end
        // status is read only
        // bit 0 clear, so a stray ctrl update would drop the enable
        apb_xfer(1'b1, STATUS_ADDR, 16'h00fe, err);
        assert (err) else begin
            check_errs++;
            $display("write to STATUS at %0t was accepted without pslverr", $time);
        end
        read_reg(CTRL_ADDR);
        assert (rdata == 16'h0001) else begin
            check_errs++;
            $display("Mismatch at %0t: CTRL read %h after STATUS write, expected 0001",
                     $time, rdata);
        end
        // disable, silent from the next frame on
        write_reg(CTRL_ADDR, 16'h0000);
        mode = MODE_IGNORE;
        wait_frame_start();
        mode = MODE_QUIET;
        repeat (2) wait_frame_start();
        finish_test("registers and disable");

        $display("%0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, assert_errs + check_errs);
        if (assert_errs + check_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: copper_top.f
+incdir+tb
hdl/copper_pkg.sv
hdl/copper_mem.sv
hdl/beam_timer.sv
hdl/copper_exec.sv
hdl/copper_apb.sv
hdl/copper_top.sv
tb/copper_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the copper testbench with verilator, run it, judge by the log
cd "$(dirname "$0")" &&
verilator --binary --assert -j 0 -f copper_top.f --top-module copper_tb -o copper_sim &&
./obj_dir/copper_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
